/* logic/usb_proto_pkg.sv */
package usb_proto_pkg;

  localparam int USB_ADDR_W = 7;

  // Low PID nibble, the wire byte carries its complement in the upper nibble
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

  typedef enum logic [1:0] {
    KIND_NONE  = 2'd0,
    KIND_TOKEN = 2'd1,
    KIND_DATA  = 2'd2,
    KIND_HSK   = 2'd3
  } usb_pkt_kind_e;

  // The two bytes after a token PID, first byte in the low half
  typedef union packed {
    struct packed {
      logic [4:0]            crc5;
      logic [3:0]            endp;
      logic [USB_ADDR_W-1:0] addr;
    } tok;
    struct packed {
      logic [4:0]  crc5;
      logic [10:0] frame;
    } sof;
  } usb_tok_field_u;

  // One decoded packet
  typedef struct packed {
    usb_pkt_kind_e  kind;
    usb_pid_e       pid;
    usb_tok_field_u field;
    logic           good;
    logic [8:0]     rsvd;
  } usb_evt_t;

endpackage

/* logic/usb_crc_pkg.sv */
package usb_crc_pkg;

  // Polynomials without the top term, registers start at all ones
  localparam logic [4:0]  CRC5_POLY      = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUAL  = 5'b01100;
  localparam logic [15:0] CRC16_POLY     = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUAL = 16'h800d;

  // Bits go in LSB first as on the bus
  // The sent CRC is the inverted register, highest bit first
  // nbits below 8 covers the 11-bit token field
  function automatic logic [4:0] crc5_update(input logic [4:0]  crc,
                                             input logic [7:0]  data,
                                             input int unsigned nbits = 8);
    logic [4:0] c;
    logic       fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (i < nbits) begin
        fb = data[i] ^ c[4];
        c  = {c[3:0], 1'b0} ^ (fb ? CRC5_POLY : 5'd0);
      end
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_update(input logic [15:0] crc,
                                               input logic [7:0]  data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = data[i] ^ c[15];
      c  = {c[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'd0);
    end
    return c;
  endfunction

endpackage

/* logic/usb_evt_if.sv */
interface usb_evt_if;
  import usb_proto_pkg::*;

  // One strobe per completed packet
  logic     evt_stb;
  usb_evt_t evt;
  // Good SOF seen, alongside evt_stb
  logic     sof_stb;

  modport decoder (
    output evt_stb,
    output evt,
    output sof_stb
  );

  modport control (
    input evt_stb,
    input evt,
    input sof_stb
  );

endinterface

/* logic/usb_rx_decode.sv */
module usb_rx_decode (
  input  logic       clock,
  input  logic       arst_n_i,
  input  logic       rx_stb_i,
  input  logic [7:0] rx_data_i,
  input  logic       rx_last_i,
  usb_evt_if.decoder evt_o
);
  import usb_proto_pkg::*;
  import usb_crc_pkg::*;

  // Index of the current byte in its packet, saturates at 3
  logic [1:0]     byte_cnt_q;
  // Index of the last byte of the finished packet
  logic [1:0]     len_q;
  logic           end_q;
  logic [7:0]     pid_q;
  usb_tok_field_u field_q;
  logic [4:0]     crc5_q;
  logic [15:0]    crc16_q;

  logic           pid_ok;
  usb_pkt_kind_e  kind;
  logic           good;
  logic           is_sof;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      byte_cnt_q <= 2'd0;
      end_q      <= 1'b0;
    end else begin
      end_q <= rx_stb_i & rx_last_i;
      if (rx_stb_i) begin
        if (rx_last_i) begin
          byte_cnt_q <= 2'd0;
        end else if (byte_cnt_q != 2'd3) begin
          byte_cnt_q <= byte_cnt_q + 2'd1;
        end
      end
    end
  end

  // PID capture, field capture and both CRCs over everything after the PID
  always_ff @(posedge clock) begin
    if (rx_stb_i) begin
      if (byte_cnt_q == 2'd0) begin
        pid_q   <= rx_data_i;
        crc5_q  <= '1;
        crc16_q <= '1;
      end else begin
        crc5_q  <= crc5_update(crc5_q, rx_data_i);
        crc16_q <= crc16_update(crc16_q, rx_data_i);
      end
      if (byte_cnt_q == 2'd1) begin
        field_q[7:0] <= rx_data_i;
      end
      if (byte_cnt_q == 2'd2) begin
        field_q[15:8] <= rx_data_i;
      end
      if (rx_last_i) begin
        len_q <= byte_cnt_q;
      end
    end
  end

  assign pid_ok = (pid_q[7:4] == ~pid_q[3:0]);

  // Kind comes from the two low PID bits, a broken PID gives no kind at all
  always_comb begin
    kind = KIND_NONE;
    good = 1'b0;
    if (pid_ok) begin
      case (pid_q[1:0])
        2'b01: begin
          kind = KIND_TOKEN;
          good = (len_q == 2'd2) && (crc5_q == CRC5_RESIDUAL);
        end
        2'b11: begin
          // PID plus at least the two CRC bytes
          kind = KIND_DATA;
          good = (len_q >= 2'd2) && (crc16_q == CRC16_RESIDUAL);
        end
        2'b10: begin
          kind = KIND_HSK;
          good = (len_q == 2'd0);
        end
        default: begin
          kind = KIND_NONE;
          good = 1'b0;
        end
      endcase
    end
  end

  assign is_sof = good && (kind == KIND_TOKEN) && (pid_q[3:0] == PID_SOF);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_o.evt_stb <= 1'b0;
      evt_o.sof_stb <= 1'b0;
    end else begin
      evt_o.evt_stb <= end_q;
      evt_o.sof_stb <= end_q & is_sof;
    end
  end

  // A following PID may land on the same edge, it only touches pid_q
  always_ff @(posedge clock) begin
    if (end_q) begin
      evt_o.evt.kind  <= kind;
      evt_o.evt.pid   <= usb_pid_e'(pid_q[3:0]);
      evt_o.evt.field <= field_q;
      evt_o.evt.good  <= good;
      evt_o.evt.rsvd  <= '0;
    end
  end

endmodule

/* logic/usb_xfer_control.sv */
module usb_xfer_control #(
  parameter int NUM_ENDP = 4
) (
  input  logic                                 clock,
  input  logic                                 arst_n_i,
  usb_evt_if.control                           evt_i,
  input  logic [usb_proto_pkg::USB_ADDR_W-1:0] dev_addr_i,
  output logic                                 dec_stb_o,
  output usb_proto_pkg::usb_pid_e              dec_pid_o,
  output logic                                 crc_err_stb_o,
  output logic                                 sof_stb_o,
  output logic [10:0]                          frame_o
);
  import usb_proto_pkg::*;

  localparam logic [1:0] PEND_NONE  = 2'd0;
  localparam logic [1:0] PEND_OUT   = 2'd1;
  localparam logic [1:0] PEND_SETUP = 2'd2;

  logic [1:0]          pend_q;
  logic [1:0]          pend_d;
  logic [3:0]          pend_ep_q;
  logic [3:0]          ep_d;
  // Expected data PID per endpoint, 0 for DATA0
  logic [NUM_ENDP-1:0] toggle_q;

  logic                addr_hit;
  logic                ep_ok;
  logic                cur_tog;
  logic                seq_match;
  logic                resp_stb;
  usb_pid_e            resp_pid;
  logic                crc_err;
  logic                tog_clr;
  logic                tog_flip;

  assign addr_hit = (evt_i.evt.field.tok.addr == dev_addr_i);
  assign ep_ok    = int'(pend_ep_q) < NUM_ENDP;

  always_comb begin
    cur_tog = 1'b0;
    for (int i = 0; i < NUM_ENDP; i++) begin
      if (pend_ep_q == 4'(i)) begin
        cur_tog = toggle_q[i];
      end
    end
  end

  assign seq_match = ((evt_i.evt.pid == PID_DATA0) && !cur_tog) ||
                     ((evt_i.evt.pid == PID_DATA1) && cur_tog);

  always_comb begin
    pend_d   = pend_q;
    ep_d     = pend_ep_q;
    resp_stb = 1'b0;
    resp_pid = PID_ACK;
    crc_err  = 1'b0;
    tog_clr  = 1'b0;
    tog_flip = 1'b0;
    if (evt_i.evt_stb) begin
      case (evt_i.evt.kind)
        KIND_TOKEN: begin
          if (!evt_i.evt.good) begin
            crc_err = 1'b1;
            pend_d  = PEND_NONE;
          end else if (evt_i.evt.pid != PID_SOF) begin
            // Any other token ends what was pending
            pend_d = PEND_NONE;
            if (addr_hit) begin
              case (evt_i.evt.pid)
                PID_IN: begin
                  resp_stb = 1'b1;
                  resp_pid = PID_NAK;
                end
                PID_OUT: begin
                  pend_d = PEND_OUT;
                  ep_d   = evt_i.evt.field.tok.endp;
                end
                PID_SETUP: begin
                  pend_d  = PEND_SETUP;
                  ep_d    = evt_i.evt.field.tok.endp;
                  tog_clr = 1'b1;
                end
                default: begin
                  pend_d = PEND_NONE;
                end
              endcase
            end
          end
        end
        KIND_DATA: begin
          if (pend_q != PEND_NONE) begin
            pend_d = PEND_NONE;
            if (!evt_i.evt.good) begin
              crc_err = 1'b1;
            end else if (!ep_ok) begin
              resp_stb = 1'b1;
              resp_pid = PID_STALL;
            end else begin
              // Wrong sequence bit is a retransmission, ACK it again
              resp_stb = 1'b1;
              resp_pid = PID_ACK;
              tog_flip = seq_match;
            end
          end
        end
        default: begin
          pend_d = pend_q;
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q        <= PEND_NONE;
      toggle_q      <= '0;
      dec_stb_o     <= 1'b0;
      crc_err_stb_o <= 1'b0;
      sof_stb_o     <= 1'b0;
    end else begin
      pend_q        <= pend_d;
      dec_stb_o     <= resp_stb;
      crc_err_stb_o <= crc_err;
      sof_stb_o     <= evt_i.sof_stb;
      for (int i = 0; i < NUM_ENDP; i++) begin
        if (tog_clr && (ep_d == 4'(i))) begin
          toggle_q[i] <= 1'b0;
        end else if (tog_flip && (pend_ep_q == 4'(i))) begin
          toggle_q[i] <= ~toggle_q[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    pend_ep_q <= ep_d;
    if (resp_stb) begin
      dec_pid_o <= resp_pid;
    end
    if (evt_i.evt_stb) begin
      frame_o <= evt_i.evt.field.sof.frame;
    end
  end

endmodule

/* logic/usb_hsk_encode.sv */
module usb_hsk_encode (
  input  logic                    clock,
  input  logic                    arst_n_i,
  input  logic                    dec_stb_i,
  input  usb_proto_pkg::usb_pid_e dec_pid_i,
  input  logic                    crc_err_stb_i,
  input  logic                    sof_stb_i,
  input  logic [10:0]             frame_i,
  output logic                    hsk_stb_o,
  output logic [7:0]              hsk_pid_o,
  output logic                    crc_err_o,
  output logic                    sof_stb_o,
  output logic [10:0]             frame_o
);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hsk_stb_o <= 1'b0;
      hsk_pid_o <= 8'h00;
      crc_err_o <= 1'b0;
      sof_stb_o <= 1'b0;
      frame_o   <= 11'd0;
    end else begin
      hsk_stb_o <= dec_stb_i;
      crc_err_o <= crc_err_stb_i;
      sof_stb_o <= sof_stb_i;
      // Full wire byte, check nibble on top
      if (dec_stb_i) begin
        hsk_pid_o <= {~dec_pid_i, dec_pid_i};
      end
      // Frame number stays until the next SOF
      if (sof_stb_i) begin
        frame_o <= frame_i;
      end
    end
  end

endmodule

/* logic/usb_device_core.sv */
module usb_device_core #(
  parameter int NUM_ENDP = 4
) (
  input  logic                                 clock,
  input  logic                                 arst_n_i,
  input  logic                                 rx_stb_i,
  input  logic [7:0]                           rx_data_i,
  input  logic                                 rx_last_i,
  input  logic [usb_proto_pkg::USB_ADDR_W-1:0] dev_addr_i,
  output logic                                 hsk_stb_o,
  output logic [7:0]                           hsk_pid_o,
  output logic                                 sof_stb_o,
  output logic [10:0]                          frame_o,
  output logic                                 crc_err_o
);
  import usb_proto_pkg::*;

  logic        dec_stb;
  usb_pid_e    dec_pid;
  logic        crc_err_stb;
  logic        ctl_sof_stb;
  logic [10:0] ctl_frame;

  usb_evt_if evt_bus ();

  // Packet decode, one event per packet
  usb_rx_decode u_rx_decode (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .rx_stb_i  (rx_stb_i),
    .rx_data_i (rx_data_i),
    .rx_last_i (rx_last_i),
    .evt_o     (evt_bus.decoder)
  );

  usb_xfer_control #(
    .NUM_ENDP (NUM_ENDP)
  ) u_xfer_control (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .evt_i         (evt_bus.control),
    .dev_addr_i    (dev_addr_i),
    .dec_stb_o     (dec_stb),
    .dec_pid_o     (dec_pid),
    .crc_err_stb_o (crc_err_stb),
    .sof_stb_o     (ctl_sof_stb),
    .frame_o       (ctl_frame)
  );

  // Output registers
  usb_hsk_encode u_hsk_encode (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .dec_stb_i     (dec_stb),
    .dec_pid_i     (dec_pid),
    .crc_err_stb_i (crc_err_stb),
    .sof_stb_i     (ctl_sof_stb),
    .frame_i       (ctl_frame),
    .hsk_stb_o     (hsk_stb_o),
    .hsk_pid_o     (hsk_pid_o),
    .crc_err_o     (crc_err_o),
    .sof_stb_o     (sof_stb_o),
    .frame_o       (frame_o)
  );

endmodule

/* test/usb_tb_vectors.svh */
`ifndef USB_TB_VECTORS_SVH
`define USB_TB_VECTORS_SVH

// Expected response of one host packet
localparam logic [1:0] RSP_NONE = 2'd0;
localparam logic [1:0] RSP_HSK  = 2'd1;
localparam logic [1:0] RSP_SOF  = 2'd2;
localparam logic [1:0] RSP_CRC  = 2'd3;

// Token field is {endp, addr} or the frame number, unused for data packets
// rsp_val is the wire PID byte of the handshake or the frame number
typedef struct {
  string       name;
  logic [6:0]  dev_addr;
  logic [7:0]  pid;
  logic [10:0] field;
  logic        corrupt;
  logic [1:0]  rsp;
  logic [10:0] rsp_val;
} vec_t;

localparam int NUM_VECS = 19;

vec_t vecs [NUM_VECS] = '{
  '{"sof_frame",     7'h2a, 8'ha5, 11'h123,          1'b0, RSP_SOF,  11'h123},
  '{"setup_tok",     7'h2a, 8'h2d, {4'd0, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"setup_data0",   7'h2a, 8'hc3, 11'h000,          1'b0, RSP_HSK,  11'h0d2},
  '{"out_tok_a",     7'h2a, 8'he1, {4'd0, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"out_data1",     7'h2a, 8'h4b, 11'h000,          1'b0, RSP_HSK,  11'h0d2},
  '{"out_tok_b",     7'h2a, 8'he1, {4'd0, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"data1_retry",   7'h2a, 8'h4b, 11'h000,          1'b0, RSP_HSK,  11'h0d2},
  '{"out_tok_c",     7'h2a, 8'he1, {4'd0, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"data0_new",     7'h2a, 8'hc3, 11'h000,          1'b0, RSP_HSK,  11'h0d2},
  '{"other_tok",     7'h2a, 8'he1, {4'd0, 7'h11},    1'b0, RSP_NONE, 11'h000},
  '{"other_data",    7'h2a, 8'hc3, 11'h000,          1'b0, RSP_NONE, 11'h000},
  '{"new_addr_tok",  7'h11, 8'he1, {4'd1, 7'h11},    1'b0, RSP_NONE, 11'h000},
  '{"new_addr_data", 7'h11, 8'hc3, 11'h000,          1'b0, RSP_HSK,  11'h0d2},
  '{"out_tok_d",     7'h2a, 8'he1, {4'd0, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"bad_crc16",     7'h2a, 8'h4b, 11'h000,          1'b1, RSP_CRC,  11'h000},
  '{"bad_crc5",      7'h2a, 8'he1, {4'd0, 7'h2a},    1'b1, RSP_CRC,  11'h000},
  '{"in_tok",        7'h2a, 8'h69, {4'd0, 7'h2a},    1'b0, RSP_HSK,  11'h05a},
  '{"ep5_tok",       7'h2a, 8'he1, {4'd5, 7'h2a},    1'b0, RSP_NONE, 11'h000},
  '{"ep5_data",      7'h2a, 8'hc3, 11'h000,          1'b0, RSP_HSK,  11'h01e}
};

`endif

/* test/usb_device_tb.sv */
module usb_device_tb;
  import usb_crc_pkg::*;

  localparam int NUM_ENDP = 4;
  // Cycles to watch for a response after the last byte
  localparam int WINDOW   = 8;

  logic        clock;
  logic        arst_n_i;
  logic        rx_stb_i;
  logic [7:0]  rx_data_i;
  logic        rx_last_i;
  logic [6:0]  dev_addr_i;
  logic        hsk_stb_o;
  logic [7:0]  hsk_pid_o;
  logic        sof_stb_o;
  logic [10:0] frame_o;
  logic        crc_err_o;

  `include "usb_tb_vectors.svh"

  // Bytes of the packet being sent
  logic [7:0] pkt [$];

  usb_device_core #(
    .NUM_ENDP (NUM_ENDP)
  ) dut0 (
    .clock      (clock),
    .arst_n_i   (arst_n_i),
    .rx_stb_i   (rx_stb_i),
    .rx_data_i  (rx_data_i),
    .rx_last_i  (rx_last_i),
    .dev_addr_i (dev_addr_i),
    .hsk_stb_o  (hsk_stb_o),
    .hsk_pid_o  (hsk_pid_o),
    .sof_stb_o  (sof_stb_o),
    .frame_o    (frame_o),
    .crc_err_o  (crc_err_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, exp_v, act_v);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Strobes with the handshake PID they qualify and the held frame number
  function automatic logic [31:0] status_word(input logic hsk, input logic sof,
                                              input logic crc, input logic [7:0] pid,
                                              input logic [10:0] frame);
    return {10'd0, hsk, sof, crc, (hsk ? pid : 8'h00), frame};
  endfunction

  function automatic string strobe_name(input logic [1:0] rsp);
    case (rsp)
      RSP_HSK: return "hsk_stb_o";
      RSP_SOF: return "sof_stb_o";
      default: return "crc_err_o";
    endcase
  endfunction

  // CRC5 goes out inverted and highest bit first on the wire
  task automatic build_token(input logic [7:0] pid, input logic [10:0] field,
                             input logic corrupt);
    logic [4:0] c;
    logic [4:0] sent;
    c = crc5_update(5'h1f, field[7:0]);
    c = crc5_update(c, {5'd0, field[10:8]}, 3);
    for (int k = 0; k < 5; k++) begin
      sent[k] = ~c[4-k];
    end
    pkt.delete();
    pkt.push_back(pid);
    pkt.push_back(field[7:0]);
    pkt.push_back({sent, field[10:8]});
    if (corrupt) begin
      pkt[2] = pkt[2] ^ 8'h80;
    end
  endtask

  // Random payload of 1 to 8 bytes followed by its CRC16
  task automatic build_data(input logic [7:0] pid, input logic corrupt);
    logic [15:0] c;
    logic [15:0] sent;
    logic [7:0]  b;
    int          len;
    pkt.delete();
    pkt.push_back(pid);
    c   = 16'hffff;
    len = 1 + int'($urandom % 8);
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      pkt.push_back(b);
      c = crc16_update(c, b);
    end
    for (int k = 0; k < 16; k++) begin
      sent[k] = ~c[15-k];
    end
    pkt.push_back(sent[7:0]);
    pkt.push_back(sent[15:8]);
    if (corrupt) begin
      pkt[pkt.size()-1] = pkt[pkt.size()-1] ^ 8'h01;
    end
  endtask

  // Returns right after the edge that samples the last byte
  task automatic send_packet(input logic [6:0] addr);
    for (int i = 0; i < pkt.size(); i++) begin
      @(posedge clock);
      dev_addr_i <= addr;
      rx_stb_i   <= 1'b1;
      rx_data_i  <= pkt[i];
      rx_last_i  <= (i == pkt.size() - 1);
    end
    @(posedge clock);
    rx_stb_i  <= 1'b0;
    rx_last_i <= 1'b0;
  endtask

  // Cycle count 0 is the falling edge right after the sampling edge
  // Outputs are taken at the first strobe or at the end of the window
  task automatic watch_outputs(output int lat, output int hits, output logic [31:0] word);
    lat  = -1;
    hits = 0;
    word = 32'd0;
    for (int cyc = 0; cyc < WINDOW; cyc++) begin
      @(negedge clock);
      if (hsk_stb_o || sof_stb_o || crc_err_o) begin
        hits++;
        if (lat < 0) begin
          lat  = cyc;
          word = status_word(hsk_stb_o, sof_stb_o, crc_err_o, hsk_pid_o, frame_o);
        end
      end else if ((lat < 0) && (cyc == WINDOW - 1)) begin
        word = status_word(1'b0, 1'b0, 1'b0, hsk_pid_o, frame_o);
      end
    end
  endtask

  initial begin
    vec_t        v;
    int          lat;
    int          hits;
    logic [31:0] word;
    logic [31:0] exp_word;
    logic [10:0] exp_frame;
    void'($urandom(32'hbbbdf517));
    arst_n_i   = 1'b0;
    rx_stb_i   = 1'b0;
    rx_data_i  = 8'h00;
    rx_last_i  = 1'b0;
    dev_addr_i = 7'h00;
    exp_frame  = 11'h000;
    repeat (16) @(posedge clock);
    arst_n_i <= 1'b1;
    @(negedge clock);
    check_value("reset", "outputs", 32'd0,
                32'({hsk_stb_o, sof_stb_o, crc_err_o, hsk_pid_o, frame_o}));

    for (int r = 0; r < NUM_VECS; r++) begin
      v = vecs[r];
      // Low PID bits 11 mark a data packet
      if (v.pid[1:0] == 2'b11) begin
        build_data(v.pid, v.corrupt);
      end else begin
        build_token(v.pid, v.field, v.corrupt);
      end
      send_packet(v.dev_addr);
      watch_outputs(lat, hits, word);
      if ((v.rsp != RSP_NONE) && (lat < 0)) begin
        $display("Timeout in test %s: %s never arrived", v.name, strobe_name(v.rsp));
        $display("Errors found");
        $fatal(1);
      end
      // Frame number holds between SOF packets
      if (v.rsp == RSP_SOF) begin
        exp_frame = v.rsp_val;
      end
      exp_word = status_word(v.rsp == RSP_HSK, v.rsp == RSP_SOF, v.rsp == RSP_CRC,
                             v.rsp_val[7:0], exp_frame);
      check_value(v.name, "response", exp_word, word);
      if (lat >= 0) begin
        check_value(v.name, "latency", 32'd3, 32'(lat));
      end
      check_value(v.name, "strobe cycles",
                  (v.rsp == RSP_NONE) ? 32'd0 : 32'd1, 32'(hits));
    end

    $display("No errors");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+test
logic/usb_proto_pkg.sv
logic/usb_crc_pkg.sv
logic/usb_evt_if.sv
logic/usb_rx_decode.sv
logic/usb_xfer_control.sv
logic/usb_hsk_encode.sv
logic/usb_device_core.sv
test/usb_device_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary -f verilog.f --top-module usb_device_tb -o usb_device_sim \
  && ./obj_dir/usb_device_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation failed"; exit 1; }

grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
